// ==== logic/cnn_shape_pkg.sv ====
package cnn_shape_pkg;

	// activations are unsigned bytes
	typedef logic [7:0] pixel_t;

	// input image
	localparam int IMG_H = 8;
	localparam int IMG_W = 8;

	// output channels of each conv stage
	localparam int C1_K = 2;
	localparam int C2_K = 4;

	// map sizes after each 2x2 pool
	localparam int P1_H = IMG_H / 2;
	localparam int P1_W = IMG_W / 2;
	localparam int P2_W = P1_W / 2;

	localparam int N_CLASS = 4;
	localparam int N_FEAT = P2_W * P2_W * C2_K;

	// pixel [col][ch] sits at bit offset (col * ch_count + ch) * 8
	typedef struct packed {
		pixel_t [IMG_W-1:0] px;
	} img_row_t;

	typedef struct packed {
		pixel_t [IMG_W-1:0][C1_K-1:0] px;
	} row1_t;

	typedef struct packed {
		pixel_t [P1_W-1:0][C1_K-1:0] px;
	} pool1_row_t;

	typedef struct packed {
		pixel_t [P1_W-1:0][C2_K-1:0] px;
	} row2_t;

	typedef struct packed {
		pixel_t [P2_W-1:0][C2_K-1:0] px;
	} pool2_row_t;

	typedef logic signed [19:0] score_t;
	typedef logic [1:0] class_t;

endpackage

// ==== logic/cnn_coef_pkg.sv ====
package cnn_coef_pkg;

	typedef logic signed [7:0] coef_t;
	typedef logic signed [15:0] bias_t;

	// right shift after accumulation, indexed by stage
	localparam int CONV_SHIFT [1:2] = '{4, 5};

	// stage 1 kernels, [out ch][row][col], single input channel
	localparam coef_t K1 [0:1][0:2][0:2] = '{
		'{'{-1, 0, 2}, '{-2, 1, 4}, '{-1, 0, 2}},
		'{'{ 1, 2, 1}, '{ 2, 5, 2}, '{ 1, 2, 1}}
	};

	localparam bias_t B1 [0:1] = '{8, -24};
	localparam bias_t B2 [0:3] = '{40, -64, 96, 16};

	// classes 0 and 1 share a bias
	localparam bias_t BD [0:3] = '{24, 24, -16, 8};

	function automatic coef_t conv_weight(input int stage, input int oc, input int ic,
			input int r, input int c);
		if (stage == 1) begin
			return K1[oc][r][c];
		end
		// stage 2 pattern, values in -3..3
		return coef_t'(((oc * 5 + ic * 3 + r * 7 + c * 2) % 7) - 3);
	endfunction

	function automatic bias_t conv_bias(input int stage, input int oc);
		if (stage == 1) begin
			return B1[oc];
		end
		return B2[oc];
	endfunction

	// feature index is (row * 2 + col) * 4 + ch
	function automatic coef_t dense_weight(input int cls, input int feat);
		return coef_t'(((cls * 7 + feat * 3) % 11) - 5);
	endfunction

	function automatic bias_t dense_bias(input int cls);
		return BD[cls];
	endfunction

endpackage

// ==== logic/image_source.sv ====
`timescale 1ns/1ps

module image_source (
	input  logic                     clk,
	input  logic                     resetn,
	input  logic                     button_i,
	input  logic                     row_we_i,
	input  logic [2:0]               row_addr_i,
	input  cnn_shape_pkg::img_row_t  row_data_i,
	input  logic                     conv_done_i,
	input  logic                     result_done_i,
	output cnn_shape_pkg::img_row_t  row_o,
	output logic                     row_valid_o,
	output logic                     busy_o
);

	cnn_shape_pkg::img_row_t frame_q [cnn_shape_pkg::IMG_H];
	logic button_q;
	logic burst_q;
	logic [3:0] rd_ptr_q;
	logic [2:0] idx;
	logic start;
	logic send;

	assign start = button_i & ~button_q & ~busy_o;
	// rows 0 and 1 go out back to back, the rest wait for conv done
	assign send = start | burst_q |
		(busy_o & conv_done_i & (rd_ptr_q != 4'(cnn_shape_pkg::IMG_H)));
	assign idx = start ? 3'd0 : rd_ptr_q[2:0];

	always_ff @(posedge clk) begin
		if (row_we_i && !busy_o) begin
			frame_q[row_addr_i] <= row_data_i;
		end
		if (send) begin
			row_o <= frame_q[idx];
		end
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			button_q <= 1'b0;
			burst_q <= 1'b0;
			rd_ptr_q <= '0;
			row_valid_o <= 1'b0;
			busy_o <= 1'b0;
		end else begin
			button_q <= button_i;
			burst_q <= start;
			row_valid_o <= send;
			if (send) begin
				rd_ptr_q <= {1'b0, idx} + 4'd1;
			end
			if (start) begin
				busy_o <= 1'b1;
			end else if (result_done_i) begin
				busy_o <= 1'b0;
			end
		end
	end

endmodule

// ==== logic/line_3_buffer.sv ====
`timescale 1ns/1ps

module line_3_buffer #(
	parameter int  H = 8,
	parameter type row_t = logic [63:0]
) (
	input  logic clk,
	input  logic resetn,
	input  row_t row_i,
	input  logic valid_i,
	input  logic conv_done_i,
	output row_t above_o,
	output row_t mid_o,
	output row_t below_o,
	output logic win_valid_o
);

	localparam int CW = $clog2(H);

	row_t prev2_q;
	row_t prev1_q;
	logic [CW-1:0] cnt_q;
	logic last_pend_q;

	// window rows, held until the next window
	always_ff @(posedge clk) begin
		if (valid_i) begin
			prev2_q <= prev1_q;
			prev1_q <= row_i;
			if (cnt_q != '0) begin
				// top window gets a zero row above
				if (cnt_q == CW'(1)) begin
					above_o <= '0;
				end else begin
					above_o <= prev2_q;
				end
				mid_o <= prev1_q;
				below_o <= row_i;
			end
		end else if (conv_done_i && last_pend_q) begin
			above_o <= prev2_q;
			mid_o <= prev1_q;
			below_o <= '0;
		end
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			cnt_q <= '0;
			last_pend_q <= 1'b0;
			win_valid_o <= 1'b0;
		end else begin
			win_valid_o <= 1'b0;
			if (valid_i) begin
				win_valid_o <= (cnt_q != '0);
				if (cnt_q == CW'(H - 1)) begin
					// last row in, final window waits for conv done
					cnt_q <= '0;
					last_pend_q <= 1'b1;
				end else begin
					cnt_q <= cnt_q + 1'b1;
				end
			end else if (conv_done_i && last_pend_q) begin
				win_valid_o <= 1'b1;
				last_pend_q <= 1'b0;
			end
		end
	end

endmodule

// ==== logic/conv_relu.sv ====
`timescale 1ns/1ps

module conv_relu #(
	parameter int  STAGE = 1,
	parameter int  W = 8,
	parameter int  D = 1,
	parameter int  K = 2,
	parameter type in_row_t = logic [63:0],
	parameter type out_row_t = logic [127:0]
) (
	input  logic     clk,
	input  logic     resetn,
	input  in_row_t  above_i,
	input  in_row_t  mid_i,
	input  in_row_t  below_i,
	input  logic     win_valid_i,
	output out_row_t row_o,
	output logic     done_o
);

	localparam int CW = $clog2(W);
	localparam int ACC_W = 24;
	localparam int SHIFT = cnn_coef_pkg::CONV_SHIFT[STAGE];

	logic [$bits(in_row_t)-1:0] win [3];
	logic [K*8-1:0] col_pix;
	logic [$bits(out_row_t)-1:0] row_q;
	logic [CW-1:0] col_q;
	logic run_q;

	assign win[0] = above_i;
	assign win[1] = mid_i;
	assign win[2] = below_i;
	assign row_o = out_row_t'(row_q);

	// one output column for all K channels
	always_comb begin
		int x;
		logic signed [ACC_W-1:0] acc;
		logic signed [ACC_W-1:0] shifted;
		col_pix = '0;
		for (int k = 0; k < K; k++) begin
			acc = cnn_coef_pkg::conv_bias(STAGE, k);
			for (int d = 0; d < D; d++) begin
				for (int r = 0; r < 3; r++) begin
					for (int c = 0; c < 3; c++) begin
						x = int'(col_q) + c - 1;
						// columns past either edge read as zero
						if (x >= 0 && x < W) begin
							acc = acc + cnn_coef_pkg::conv_weight(STAGE, k, d, r, c)
								* $signed({1'b0, win[r][(x * D + d) * 8 +: 8]});
						end
					end
				end
			end
			shifted = acc >>> SHIFT;
			// relu, then clip to a byte
			if (shifted < 0) begin
				col_pix[k * 8 +: 8] = 8'd0;
			end else if (shifted > 255) begin
				col_pix[k * 8 +: 8] = 8'd255;
			end else begin
				col_pix[k * 8 +: 8] = shifted[7:0];
			end
		end
	end

	always_ff @(posedge clk) begin
		if (run_q) begin
			row_q[col_q * (K * 8) +: K * 8] <= col_pix;
		end
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			run_q <= 1'b0;
			col_q <= '0;
			done_o <= 1'b0;
		end else begin
			done_o <= 1'b0;
			if (win_valid_i) begin
				run_q <= 1'b1;
				col_q <= '0;
			end else if (run_q) begin
				col_q <= col_q + 1'b1;
				// last column lands with done
				if (col_q == CW'(W - 1)) begin
					run_q <= 1'b0;
					done_o <= 1'b1;
				end
			end
		end
	end

endmodule

// ==== logic/max_pool_rows.sv ====
`timescale 1ns/1ps

module max_pool_rows #(
	parameter int  W = 8,
	parameter int  D = 2,
	parameter type in_row_t = logic [127:0],
	parameter type out_row_t = logic [63:0]
) (
	input  logic     clk,
	input  logic     resetn,
	input  in_row_t  row_i,
	input  logic     valid_i,
	output out_row_t row_o,
	output logic     valid_o
);

	logic [$bits(in_row_t)-1:0] even_q;
	logic [$bits(in_row_t)-1:0] odd_flat;
	logic [$bits(out_row_t)-1:0] pooled;
	logic odd_q;

	assign odd_flat = row_i;

	// max over each 2x2 block, per channel
	always_comb begin
		cnn_shape_pkg::pixel_t m;
		pooled = '0;
		for (int j = 0; j < W / 2; j++) begin
			for (int d = 0; d < D; d++) begin
				m = '0;
				for (int x = 2 * j; x < 2 * j + 2; x++) begin
					if (even_q[(x * D + d) * 8 +: 8] > m) begin
						m = even_q[(x * D + d) * 8 +: 8];
					end
					if (odd_flat[(x * D + d) * 8 +: 8] > m) begin
						m = odd_flat[(x * D + d) * 8 +: 8];
					end
				end
				pooled[(j * D + d) * 8 +: 8] = m;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (valid_i && !odd_q) begin
			even_q <= row_i;
		end
		if (valid_i && odd_q) begin
			row_o <= out_row_t'(pooled);
		end
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			odd_q <= 1'b0;
			valid_o <= 1'b0;
		end else begin
			valid_o <= valid_i & odd_q;
			if (valid_i) begin
				odd_q <= ~odd_q;
			end
		end
	end

endmodule

// ==== logic/dense_classify.sv ====
`timescale 1ns/1ps

module dense_classify (
	input  logic                       clk,
	input  logic                       resetn,
	input  cnn_shape_pkg::pool2_row_t  row_i,
	input  logic                       valid_i,
	input  logic [1:0]                 sw_i,
	output cnn_shape_pkg::class_t      class_o,
	output logic [7:0]                 led_o,
	output logic                       result_valid_o
);

	localparam int NF = cnn_shape_pkg::N_FEAT;
	localparam int NC = cnn_shape_pkg::N_CLASS;
	localparam int SW = $clog2(NF);
	localparam int RW = $bits(cnn_shape_pkg::pool2_row_t);

	logic [NF*8-1:0] feat_q;
	logic row_sel_q;
	logic run_q;
	logic [SW-1:0] step_q;
	cnn_shape_pkg::pixel_t feat_cur;
	cnn_shape_pkg::score_t acc_q [NC];
	cnn_shape_pkg::score_t score_q [NC];
	cnn_shape_pkg::score_t prod [NC];

	assign feat_cur = feat_q[step_q * 8 +: 8];

	// current feature times each class weight
	always_comb begin
		cnn_coef_pkg::coef_t w;
		for (int k = 0; k < NC; k++) begin
			w = '0;
			for (int j = 0; j < NF; j++) begin
				if (step_q == SW'(j)) begin
					w = cnn_coef_pkg::dense_weight(k, j);
				end
			end
			prod[k] = w * $signed({1'b0, feat_cur});
		end
	end

	always_ff @(posedge clk) begin
		if (valid_i) begin
			feat_q[row_sel_q * RW +: RW] <= row_i;
		end
		for (int k = 0; k < NC; k++) begin
			if (valid_i && row_sel_q) begin
				acc_q[k] <= cnn_coef_pkg::dense_bias(k);
			end else if (run_q) begin
				acc_q[k] <= acc_q[k] + prod[k];
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			row_sel_q <= 1'b0;
			run_q <= 1'b0;
			step_q <= '0;
			result_valid_o <= 1'b0;
			for (int k = 0; k < NC; k++) begin
				score_q[k] <= '0;
			end
		end else begin
			result_valid_o <= 1'b0;
			if (valid_i) begin
				row_sel_q <= ~row_sel_q;
				// second row starts the MAC run
				if (row_sel_q) begin
					run_q <= 1'b1;
					step_q <= '0;
				end
			end
			if (run_q) begin
				step_q <= step_q + 1'b1;
				if (step_q == SW'(NF - 1)) begin
					run_q <= 1'b0;
					result_valid_o <= 1'b1;
					for (int k = 0; k < NC; k++) begin
						score_q[k] <= acc_q[k] + prod[k];
					end
				end
			end
		end
	end

	// argmax, ties keep the lower index
	always_comb begin
		cnn_shape_pkg::class_t best;
		cnn_shape_pkg::score_t sel;
		best = '0;
		for (int k = 1; k < NC; k++) begin
			if (score_q[k] > score_q[best]) begin
				best = cnn_shape_pkg::class_t'(k);
			end
		end
		class_o = best;
		sel = score_q[sw_i];
		if (sel < 0) begin
			led_o = 8'd0;
		end else if (sel > 255) begin
			led_o = 8'd255;
		end else begin
			led_o = sel[7:0];
		end
	end

endmodule

// ==== logic/cnn_top.sv ====
`timescale 1ns/1ps

module cnn_top (
	input  logic                     clk,
	input  logic                     resetn,
	input  logic [1:0]               sw_i,
	input  logic                     button_i,
	input  logic                     row_we_i,
	input  logic [2:0]               row_addr_i,
	input  cnn_shape_pkg::img_row_t  row_data_i,
	output logic [7:0]               led_o,
	output cnn_shape_pkg::class_t    class_o,
	output logic                     result_valid_o,
	output logic                     busy_o
);

	cnn_shape_pkg::img_row_t src_row;
	cnn_shape_pkg::img_row_t lb1_above;
	cnn_shape_pkg::img_row_t lb1_mid;
	cnn_shape_pkg::img_row_t lb1_below;
	cnn_shape_pkg::row1_t conv1_row;
	cnn_shape_pkg::pool1_row_t pool1_row;
	cnn_shape_pkg::pool1_row_t lb2_above;
	cnn_shape_pkg::pool1_row_t lb2_mid;
	cnn_shape_pkg::pool1_row_t lb2_below;
	cnn_shape_pkg::row2_t conv2_row;
	cnn_shape_pkg::pool2_row_t pool2_row;
	logic src_valid;
	logic lb1_win_valid;
	logic conv1_done;
	logic pool1_valid;
	logic lb2_win_valid;
	logic conv2_done;
	logic pool2_valid;

	image_source u_image_source (
		.clk(clk), .resetn(resetn), .button_i(button_i),
		.row_we_i(row_we_i), .row_addr_i(row_addr_i), .row_data_i(row_data_i),
		.conv_done_i(conv1_done), .result_done_i(result_valid_o),
		.row_o(src_row), .row_valid_o(src_valid), .busy_o(busy_o)
	);

	line_3_buffer #(.H(cnn_shape_pkg::IMG_H), .row_t(cnn_shape_pkg::img_row_t)) u_line_buf_1 (
		.clk(clk), .resetn(resetn), .row_i(src_row), .valid_i(src_valid),
		.conv_done_i(conv1_done), .above_o(lb1_above), .mid_o(lb1_mid),
		.below_o(lb1_below), .win_valid_o(lb1_win_valid)
	);

	conv_relu #(
		.STAGE(1), .W(cnn_shape_pkg::IMG_W), .D(1), .K(cnn_shape_pkg::C1_K),
		.in_row_t(cnn_shape_pkg::img_row_t), .out_row_t(cnn_shape_pkg::row1_t)
	) u_conv_1 (
		.clk(clk), .resetn(resetn), .above_i(lb1_above), .mid_i(lb1_mid),
		.below_i(lb1_below), .win_valid_i(lb1_win_valid),
		.row_o(conv1_row), .done_o(conv1_done)
	);

	max_pool_rows #(
		.W(cnn_shape_pkg::IMG_W), .D(cnn_shape_pkg::C1_K),
		.in_row_t(cnn_shape_pkg::row1_t), .out_row_t(cnn_shape_pkg::pool1_row_t)
	) u_pool_1 (
		.clk(clk), .resetn(resetn), .row_i(conv1_row), .valid_i(conv1_done),
		.row_o(pool1_row), .valid_o(pool1_valid)
	);

	line_3_buffer #(.H(cnn_shape_pkg::P1_H), .row_t(cnn_shape_pkg::pool1_row_t)) u_line_buf_2 (
		.clk(clk), .resetn(resetn), .row_i(pool1_row), .valid_i(pool1_valid),
		.conv_done_i(conv2_done), .above_o(lb2_above), .mid_o(lb2_mid),
		.below_o(lb2_below), .win_valid_o(lb2_win_valid)
	);

	conv_relu #(
		.STAGE(2), .W(cnn_shape_pkg::P1_W), .D(cnn_shape_pkg::C1_K), .K(cnn_shape_pkg::C2_K),
		.in_row_t(cnn_shape_pkg::pool1_row_t), .out_row_t(cnn_shape_pkg::row2_t)
	) u_conv_2 (
		.clk(clk), .resetn(resetn), .above_i(lb2_above), .mid_i(lb2_mid),
		.below_i(lb2_below), .win_valid_i(lb2_win_valid),
		.row_o(conv2_row), .done_o(conv2_done)
	);

	max_pool_rows #(
		.W(cnn_shape_pkg::P1_W), .D(cnn_shape_pkg::C2_K),
		.in_row_t(cnn_shape_pkg::row2_t), .out_row_t(cnn_shape_pkg::pool2_row_t)
	) u_pool_2 (
		.clk(clk), .resetn(resetn), .row_i(conv2_row), .valid_i(conv2_done),
		.row_o(pool2_row), .valid_o(pool2_valid)
	);

	dense_classify u_dense (
		.clk(clk), .resetn(resetn), .row_i(pool2_row), .valid_i(pool2_valid),
		.sw_i(sw_i), .class_o(class_o), .led_o(led_o), .result_valid_o(result_valid_o)
	);

endmodule

// ==== dv/tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock #(
	parameter int PERIOD = 10
) (
	output logic clk_o
);

	initial begin
		clk_o = 1'b0;
	end

	always #(PERIOD / 2) clk_o = ~clk_o;

endmodule

// ==== dv/cnn_tb.sv ====
`timescale 1ns/1ps

module cnn_tb;

	// one frame run per test
	localparam int N_TESTS = 12;
	localparam int WATCHDOG_CYCLES = N_TESTS * 2000;

	logic clk;
	logic resetn;
	logic [1:0] sw_i;
	logic button_i;
	logic row_we_i;
	logic [2:0] row_addr_i;
	cnn_shape_pkg::img_row_t row_data_i;
	logic [7:0] led_o;
	cnn_shape_pkg::class_t class_o;
	logic result_valid_o;
	logic busy_o;

	int img [0:7][0:7];
	int exp_score [0:3];
	cnn_shape_pkg::class_t exp_class;
	logic [31:0] lfsr_q;
	int errors;
	int checks;
	int rv_count;
	string wait_name;

	tb_clock #(.PERIOD(10)) u_clock (.clk_o(clk));

	cnn_top dut0 (
		.clk(clk), .resetn(resetn), .sw_i(sw_i), .button_i(button_i),
		.row_we_i(row_we_i), .row_addr_i(row_addr_i), .row_data_i(row_data_i),
		.led_o(led_o), .class_o(class_o), .result_valid_o(result_valid_o), .busy_o(busy_o)
	);

	// every result pulse seen by the testbench
	always @(posedge clk) begin
		if (result_valid_o) begin
			rv_count <= rv_count + 1;
		end
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("watchdog expired while waiting for %s", wait_name);
		$display("RESULT: FAIL");
		$finish;
	end

	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		if (s[0]) begin
			return (s >> 1) ^ 32'h8020_0003;
		end
		return s >> 1;
	endfunction

	task automatic random_byte(output int v);
		v = 0;
		for (int i = 0; i < 8; i++) begin
			lfsr_q = lfsr_step(lfsr_q);
			v = (v << 1) | int'(lfsr_q[0]);
		end
	endtask

	function automatic int relu_sat(input int acc, input int shift);
		int v;
		v = acc >>> shift;
		if (v < 0) begin
			return 0;
		end
		if (v > 255) begin
			return 255;
		end
		return v;
	endfunction

	function automatic logic [7:0] clip_byte(input int v);
		if (v < 0) begin
			return 8'd0;
		end
		if (v > 255) begin
			return 8'd255;
		end
		return 8'(v);
	endfunction

	function automatic int max4(input int a, input int b, input int c, input int d);
		int m;
		m = a;
		m = (b > m) ? b : m;
		m = (c > m) ? c : m;
		m = (d > m) ? d : m;
		return m;
	endfunction

	// reference network on img into exp_score and exp_class
	task automatic model_scores();
		int c1 [0:1][0:7][0:7];
		int p1 [0:1][0:3][0:3];
		int c2 [0:3][0:3][0:3];
		int p2 [0:3][0:1][0:1];
		int acc;
		int rr;
		int cc;
		for (int k = 0; k < 2; k++) begin
			for (int r = 0; r < 8; r++) begin
				for (int c = 0; c < 8; c++) begin
					acc = int'(cnn_coef_pkg::conv_bias(1, k));
					for (int i = 0; i < 3; i++) begin
						for (int j = 0; j < 3; j++) begin
							rr = r + i - 1;
							cc = c + j - 1;
							if (rr >= 0 && rr < 8 && cc >= 0 && cc < 8) begin
								acc += int'(cnn_coef_pkg::conv_weight(1, k, 0, i, j)) * img[rr][cc];
							end
						end
					end
					c1[k][r][c] = relu_sat(acc, cnn_coef_pkg::CONV_SHIFT[1]);
				end
			end
		end
		for (int k = 0; k < 2; k++) begin
			for (int r = 0; r < 4; r++) begin
				for (int c = 0; c < 4; c++) begin
					p1[k][r][c] = max4(c1[k][2*r][2*c], c1[k][2*r][2*c+1],
						c1[k][2*r+1][2*c], c1[k][2*r+1][2*c+1]);
				end
			end
		end
		for (int k = 0; k < 4; k++) begin
			for (int r = 0; r < 4; r++) begin
				for (int c = 0; c < 4; c++) begin
					acc = int'(cnn_coef_pkg::conv_bias(2, k));
					for (int d = 0; d < 2; d++) begin
						for (int i = 0; i < 3; i++) begin
							for (int j = 0; j < 3; j++) begin
								rr = r + i - 1;
								cc = c + j - 1;
								if (rr >= 0 && rr < 4 && cc >= 0 && cc < 4) begin
									acc += int'(cnn_coef_pkg::conv_weight(2, k, d, i, j))
										* p1[d][rr][cc];
								end
							end
						end
					end
					c2[k][r][c] = relu_sat(acc, cnn_coef_pkg::CONV_SHIFT[2]);
				end
			end
		end
		for (int k = 0; k < 4; k++) begin
			for (int r = 0; r < 2; r++) begin
				for (int c = 0; c < 2; c++) begin
					p2[k][r][c] = max4(c2[k][2*r][2*c], c2[k][2*r][2*c+1],
						c2[k][2*r+1][2*c], c2[k][2*r+1][2*c+1]);
				end
			end
		end
		for (int k = 0; k < 4; k++) begin
			acc = int'(cnn_coef_pkg::dense_bias(k));
			for (int r = 0; r < 2; r++) begin
				for (int c = 0; c < 2; c++) begin
					for (int ch = 0; ch < 4; ch++) begin
						acc += int'(cnn_coef_pkg::dense_weight(k, (r * 2 + c) * 4 + ch))
							* p2[ch][r][c];
					end
				end
			end
			exp_score[k] = acc;
		end
		// strict compare keeps the lower class on a tie
		exp_class = '0;
		for (int k = 1; k < 4; k++) begin
			if (exp_score[k] > exp_score[exp_class]) begin
				exp_class = cnn_shape_pkg::class_t'(k);
			end
		end
	endtask

	task automatic compare_led(input string name, input logic [7:0] exp, input logic [7:0] act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("Mismatch %s led: expected %0d actual %0d", name, exp, act);
		end
	endtask

	task automatic compare_class(input string name, input cnn_shape_pkg::class_t exp,
			input cnn_shape_pkg::class_t act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("Mismatch %s class: expected %0d actual %0d", name, exp, act);
		end
	endtask

	// selects the score on sw_i and checks its clipped led value
	task automatic compare_score(input string name, input int sel,
			input cnn_shape_pkg::score_t exp);
		logic [7:0] want;
		want = clip_byte(int'(exp));
		@(posedge clk);
		sw_i <= 2'(sel);
		@(negedge clk);
		checks++;
		if (led_o !== want) begin
			errors++;
			$display("Mismatch %s sw=%0d: expected %0d (score %0d) actual %0d",
				name, sel, want, exp, led_o);
		end
	endtask

	task automatic fill_frame(input int v);
		for (int r = 0; r < 8; r++) begin
			for (int c = 0; c < 8; c++) begin
				img[r][c] = v;
			end
		end
	endtask

	task automatic load_frame();
		cnn_shape_pkg::img_row_t row;
		for (int r = 0; r < 8; r++) begin
			for (int c = 0; c < 8; c++) begin
				row.px[c] = 8'(img[r][c]);
			end
			@(posedge clk);
			row_we_i <= 1'b1;
			row_addr_i <= 3'(r);
			row_data_i <= row;
		end
		@(posedge clk);
		row_we_i <= 1'b0;
	endtask

	task automatic press_button(input string name);
		@(posedge clk);
		button_i <= 1'b1;
		@(posedge clk);
		button_i <= 1'b0;
		@(negedge clk);
		checks++;
		if (busy_o !== 1'b1) begin
			errors++;
			$display("%s: busy_o did not rise after the button press", name);
		end
	endtask

	task automatic wait_result(input string name);
		wait_name = {name, " result_valid_o"};
		@(negedge clk);
		while (result_valid_o !== 1'b1) begin
			@(negedge clk);
		end
		wait_name = "the end of the test sequence";
	endtask

	task automatic check_result(input string name);
		for (int sel = 0; sel < 4; sel++) begin
			compare_score(name, sel, cnn_shape_pkg::score_t'(exp_score[sel]));
		end
		compare_class(name, exp_class, class_o);
	endtask

	task automatic run_frame(input string name);
		model_scores();
		load_frame();
		press_button(name);
		wait_result(name);
		check_result(name);
	endtask

	task automatic test_reset();
		@(negedge clk);
		compare_led("reset", 8'd0, led_o);
		compare_class("reset", '0, class_o);
		checks++;
		if (result_valid_o !== 1'b0 || busy_o !== 1'b0) begin
			errors++;
			$display("reset: result_valid_o or busy_o is not low after reset");
		end
	endtask

	// biases alone drive both stages
	task automatic test_zero_frame();
		fill_frame(0);
		run_frame("zero_frame");
	endtask

	task automatic test_patterns();
		fill_frame(0);
		img[0][0] = 255;
		run_frame("corner_pixel");
		fill_frame(0);
		for (int r = 0; r < 8; r++) begin
			img[r][3] = 255;
		end
		run_frame("vertical_bar");
		fill_frame(255);
		run_frame("full_white");
	endtask

	task automatic test_random();
		for (int n = 0; n < 4; n++) begin
			for (int r = 0; r < 8; r++) begin
				for (int c = 0; c < 8; c++) begin
					random_byte(img[r][c]);
				end
			end
			run_frame($sformatf("random_%0d", n));
		end
	endtask

	task automatic test_button_during_run();
		int count_before;
		fill_frame(0);
		for (int r = 0; r < 8; r++) begin
			img[r][7 - r] = 200;
			img[r][r] = 90;
		end
		model_scores();
		load_frame();
		press_button("button_during_run");
		repeat (20) @(posedge clk);
		// second press plus a host write to row 7, which is not replayed yet
		button_i <= 1'b1;
		row_we_i <= 1'b1;
		row_addr_i <= 3'd7;
		row_data_i <= '1;
		@(posedge clk);
		button_i <= 1'b0;
		row_we_i <= 1'b0;
		count_before = rv_count;
		wait_result("button_during_run");
		check_result("button_during_run");
		repeat (200) @(posedge clk);
		@(negedge clk);
		checks++;
		if (rv_count != count_before + 1 || busy_o !== 1'b0) begin
			errors++;
			$display("button_during_run: a second run followed the ignored button press");
		end
		for (int r = 0; r < 8; r++) begin
			for (int c = 0; c < 8; c++) begin
				img[r][c] = c * 32 + r * 3;
			end
		end
		run_frame("second_frame");
	endtask

	task automatic test_sw_change();
		int count_before;
		count_before = rv_count;
		for (int sel = 3; sel >= 0; sel--) begin
			compare_score("sw_change", sel, cnn_shape_pkg::score_t'(exp_score[sel]));
		end
		compare_class("sw_change", exp_class, class_o);
		checks++;
		if (rv_count != count_before || busy_o !== 1'b0) begin
			errors++;
			$display("sw_change: switching sw_i started a run or pulsed result_valid_o");
		end
	endtask

	initial begin
		resetn = 1'b0;
		sw_i = 2'd0;
		button_i = 1'b0;
		row_we_i = 1'b0;
		row_addr_i = 3'd0;
		row_data_i = '0;
		lfsr_q = 32'hbd2b_7065;
		errors = 0;
		checks = 0;
		rv_count = 0;
		wait_name = "reset";
		repeat (8) @(posedge clk);
		resetn <= 1'b1;
		test_reset();
		test_zero_frame();
		test_patterns();
		test_random();
		test_button_during_run();
		test_sw_change();
		$display("checks: %0d  errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

endmodule

// ==== filelist.f ====
logic/cnn_shape_pkg.sv
logic/cnn_coef_pkg.sv
logic/image_source.sv
logic/line_3_buffer.sv
logic/conv_relu.sv
logic/max_pool_rows.sv
logic/dense_classify.sv
logic/cnn_top.sv
dv/tb_clock.sv
dv/cnn_tb.sv
